// ==== rtl/decimator_pkg.sv ====
// Multichannel averaging decimator shared definitions
// Sample, tag and accumulator widths, channel count and ratio limits
// Used by every RTL stage and by the testbench reference model

package decimator_pkg;

    // Width of one input and output sample
    localparam int data_width = 16;

    // Width of the destination tag carried with each sample
    localparam int dest_width = 8;

    // Active channels, tags at or above this are dropped
    localparam int n_channels = 4;

    // Bits needed to index one active channel
    localparam int chan_width = 2;

    // Width of the decimation ratio input
    localparam int ratio_width = 4;

    // Smallest usable ratio, a zero request is raised to this
    localparam int min_ratio = 1;

    // Running sum width
    // 15 full-scale samples need 4 extra bits above the sample width
    localparam int sum_width = data_width + ratio_width;

endpackage

// ==== rtl/channel_decode.sv ====
// Decoder stage of the averaging decimator
// Filters samples by channel tag and registers the accepted ones
// Holds the clamped decimation ratio and flags every change of it

module channel_decode (
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic                                  in_valid,
    input  logic [decimator_pkg::data_width-1:0]  in_data,
    input  logic [decimator_pkg::dest_width-1:0]  in_dest,
    input  logic [decimator_pkg::ratio_width-1:0] decimation_ratio,
    output logic                                  dec_valid,
    output logic [decimator_pkg::data_width-1:0]  dec_sample,
    output logic [decimator_pkg::chan_width-1:0]  dec_chan,
    output logic [decimator_pkg::ratio_width-1:0] ratio_q,
    output logic                                  flush
);
    import decimator_pkg::*;

    logic                   chan_ok;
    logic [ratio_width-1:0] ratio_clamped;

    always_comb begin
        // Only the low channel tags are served
        chan_ok = (in_dest < dest_width'(n_channels));
        // A zero ratio would never close a block
        if (decimation_ratio == '0) begin
            ratio_clamped = ratio_width'(min_ratio);
        end else begin
            ratio_clamped = decimation_ratio;
        end
    end

    // Sample strobe
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid && chan_ok;
        end
    end

    // Payload only moves with an accepted sample
    always_ff @(posedge clock) begin
        if (in_valid && chan_ok) begin
            dec_sample <= in_data;
            dec_chan   <= in_dest[chan_width-1:0];
        end
    end

    // Ratio tracking
    // Stored ratio starts at zero so the first real value flushes
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ratio_q <= '0;
            flush   <= 1'b0;
        end else begin
            ratio_q <= ratio_clamped;
            flush   <= (ratio_clamped != ratio_q);
        end
    end

    // Upstream must leave a gap around ratio changes
    // otherwise a sample lands in the same cycle as the flush and is lost
    a_no_sample_on_flush: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(dec_valid && flush)
    );

endmodule

// ==== rtl/channel_accumulator.sv ====
// Accumulator stage of the averaging decimator
// Keeps one running sum and one sample count per channel
// Releases a block sum, its channel and its ratio when the count
// reaches the decimation ratio, then restarts that channel
// A flush discards every partial block

module channel_accumulator (
    input  logic                                      clock,
    input  logic                                      rst_n,
    input  logic                                      dec_valid,
    input  logic [decimator_pkg::data_width-1:0]      dec_sample,
    input  logic [decimator_pkg::chan_width-1:0]      dec_chan,
    input  logic [decimator_pkg::ratio_width-1:0]     ratio_q,
    input  logic                                      flush,
    output logic                                      blk_valid,
    output logic signed [decimator_pkg::sum_width-1:0] blk_sum,
    output logic [decimator_pkg::chan_width-1:0]      blk_chan,
    output logic [decimator_pkg::ratio_width-1:0]     blk_ratio
);
    import decimator_pkg::*;

    // Per channel state
    logic signed [sum_width-1:0]   sum_q [n_channels];
    logic        [ratio_width-1:0] cnt_q [n_channels];

    logic signed [sum_width-1:0]   sample_ext;
    logic signed [sum_width-1:0]   sum_next;
    logic        [ratio_width-1:0] cnt_next;
    logic                          blk_done;

    always_comb begin
        // Sign extend the sample to the accumulator width
        sample_ext = {{(sum_width - data_width){dec_sample[data_width-1]}}, dec_sample};
        sum_next   = sum_q[dec_chan] + sample_ext;
        // Count after this sample is added
        cnt_next   = cnt_q[dec_chan] + ratio_width'(1);
        // Flush wins over a sample in the same cycle
        blk_done   = dec_valid && !flush && (cnt_next >= ratio_q);
    end

    // Sums and counts
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < n_channels; i++) begin
                sum_q[i] <= '0;
                cnt_q[i] <= '0;
            end
        end else if (flush) begin
            // Ratio changed so every partial block is void
            for (int i = 0; i < n_channels; i++) begin
                sum_q[i] <= '0;
                cnt_q[i] <= '0;
            end
        end else if (dec_valid) begin
            if (blk_done) begin
                // Block closes and the channel restarts from zero
                sum_q[dec_chan] <= '0;
                cnt_q[dec_chan] <= '0;
            end else begin
                sum_q[dec_chan] <= sum_next;
                cnt_q[dec_chan] <= cnt_next;
            end
        end
    end

    // Block strobe
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            blk_valid <= 1'b0;
        end else begin
            blk_valid <= blk_done;
        end
    end

    // Block payload
    // the ratio travels along so the divider uses the one that built the sum
    always_ff @(posedge clock) begin
        if (blk_done) begin
            blk_sum   <= sum_next;
            blk_chan  <= dec_chan;
            blk_ratio <= ratio_q;
        end
    end

    // Counts stay within the ratio; a lower ratio arrives
    // together with the flush from the decode stage
    for (genvar g = 0; g < n_channels; g++) begin : g_cnt_chk
        a_cnt_limit: assert property (
            @(posedge clock) disable iff (!rst_n)
            !flush |-> (cnt_q[g] <= ratio_q)
        );
    end

endmodule

// ==== rtl/average_output.sv ====
// Output stage of the averaging decimator
// Divides a finished block sum by its ratio, truncating toward zero,
// and registers the averaged sample with its destination tag

module average_output (
    input  logic                                       clock,
    input  logic                                       rst_n,
    input  logic                                       blk_valid,
    input  logic signed [decimator_pkg::sum_width-1:0] blk_sum,
    input  logic [decimator_pkg::chan_width-1:0]       blk_chan,
    input  logic [decimator_pkg::ratio_width-1:0]      blk_ratio,
    output logic                                       out_valid,
    output logic [decimator_pkg::data_width-1:0]       out_data,
    output logic [decimator_pkg::dest_width-1:0]       out_dest
);
    import decimator_pkg::*;

    logic signed [sum_width-1:0] divisor;
    logic signed [sum_width-1:0] quotient;

    always_comb begin
        // Ratio as a positive signed operand
        divisor  = {{(sum_width - ratio_width){1'b0}}, blk_ratio};
        // Signed division truncates toward zero
        quotient = blk_sum / divisor;
    end

    // Output strobe, one pulse per block
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= blk_valid;
        end
    end

    // Mean of data_width samples always fits data_width
    always_ff @(posedge clock) begin
        if (blk_valid) begin
            out_data <= quotient[data_width-1:0];
            out_dest <= {{(dest_width - chan_width){1'b0}}, blk_chan};
        end
    end

    // Decode clamps zero requests, so a block never carries ratio zero
    a_ratio_nonzero: assert property (
        @(posedge clock) disable iff (!rst_n)
        blk_valid |-> (blk_ratio != '0)
    );

endmodule

// ==== rtl/standard_decimator.sv ====
// Multichannel averaging decimator top level
// Decode, accumulate and divide stages in a three cycle pipeline
// One averaged sample per channel for every ratio input samples

module standard_decimator (
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic                                  in_valid,
    input  logic [decimator_pkg::data_width-1:0]  in_data,
    input  logic [decimator_pkg::dest_width-1:0]  in_dest,
    input  logic [decimator_pkg::ratio_width-1:0] decimation_ratio,
    output logic                                  out_valid,
    output logic [decimator_pkg::data_width-1:0]  out_data,
    output logic [decimator_pkg::dest_width-1:0]  out_dest
);
    import decimator_pkg::*;

    // Decode to accumulator
    logic                    dec_valid;
    logic [data_width-1:0]   dec_sample;
    logic [chan_width-1:0]   dec_chan;
    logic [ratio_width-1:0]  ratio_q;
    logic                    flush;

    // Accumulator to divider
    logic                        blk_valid;
    logic signed [sum_width-1:0] blk_sum;
    logic [chan_width-1:0]       blk_chan;
    logic [ratio_width-1:0]      blk_ratio;

    channel_decode u_decode (
        .clock            (clock),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_data          (in_data),
        .in_dest          (in_dest),
        .decimation_ratio (decimation_ratio),
        .dec_valid        (dec_valid),
        .dec_sample       (dec_sample),
        .dec_chan         (dec_chan),
        .ratio_q          (ratio_q),
        .flush            (flush)
    );

    channel_accumulator u_accumulator (
        .clock      (clock),
        .rst_n      (rst_n),
        .dec_valid  (dec_valid),
        .dec_sample (dec_sample),
        .dec_chan   (dec_chan),
        .ratio_q    (ratio_q),
        .flush      (flush),
        .blk_valid  (blk_valid),
        .blk_sum    (blk_sum),
        .blk_chan   (blk_chan),
        .blk_ratio  (blk_ratio)
    );

    average_output u_output (
        .clock     (clock),
        .rst_n     (rst_n),
        .blk_valid (blk_valid),
        .blk_sum   (blk_sum),
        .blk_chan  (blk_chan),
        .blk_ratio (blk_ratio),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_dest  (out_dest)
    );

endmodule

// ==== testbench/clock_gen.sv ====
// Testbench clock source for the averaging decimator
// Free running clock with a period of 20 time units

module clock_gen (
    output logic clock
);

    // Half of the 20 unit period
    localparam int half_period = 10;

    initial begin
        clock = 1'b0;
    end

    always begin
        #half_period clock = ~clock;
    end

endmodule

// ==== testbench/decimator_tb.sv ====
// Directed testbench for the multichannel averaging decimator
// A reference model builds the expected averages per channel,
// a monitor collects every output pulse, and each test compares both
// Random data comes from a Galois LFSR stepped once per bit

module decimator_tb;
    import decimator_pkg::*;

    // Tests take about 650 cycles, limit leaves a wide margin
    localparam int cycle_limit = 3000;
    // Stages between an accepted sample and out_valid
    localparam int pipe_depth = 3;

    logic                   clock;
    logic                   rst_n;
    logic                   in_valid;
    logic [data_width-1:0]  in_data;
    logic [dest_width-1:0]  in_dest;
    logic [ratio_width-1:0] decimation_ratio;
    logic                   out_valid;
    logic [data_width-1:0]  out_data;
    logic [dest_width-1:0]  out_dest;

    // Reference model state
    int model_sum [n_channels];
    int model_cnt [n_channels];
    int model_ratio;
    int blocks_done;

    // Expected and observed outputs in arrival order
    logic [data_width-1:0] exp_data [$];
    logic [dest_width-1:0] exp_dest [$];
    logic [data_width-1:0] got_data [$];
    logic [dest_width-1:0] got_dest [$];
    time                   got_time [$];

    logic [31:0] lfsr_state;
    int cycle_count;
    int outputs_seen;
    int error_count;
    int check_count;
    int tests_run;
    int tests_failed;

    clock_gen u_clock (
        .clock (clock)
    );

    standard_decimator dut0 (
        .clock            (clock),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_data          (in_data),
        .in_dest          (in_dest),
        .decimation_ratio (decimation_ratio),
        .out_valid        (out_valid),
        .out_data         (out_data),
        .out_dest         (out_dest)
    );

    // Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

    // Zero request acts as one, any real change voids partial blocks
    function automatic void model_set_ratio(input int r);
        int clamped;
        clamped = (r == 0) ? 1 : r;
        if (clamped != model_ratio) begin
            model_sum = '{default: 0};
            model_cnt = '{default: 0};
        end
        model_ratio = clamped;
    endfunction

    // Block mean truncates toward zero, tags beyond the channels vanish
    function automatic void model_add(input int d, input int tag);
        logic signed [data_width-1:0] s;
        logic [chan_width-1:0]        ch;
        int                           q;
        s  = d[data_width-1:0];
        ch = tag[chan_width-1:0];
        if (tag < n_channels) begin
            model_sum[ch] = model_sum[ch] + int'(s);
            model_cnt[ch] = model_cnt[ch] + 1;
            if (model_cnt[ch] == model_ratio) begin
                q = model_sum[ch] / model_ratio;
                exp_data.push_back(q[data_width-1:0]);
                exp_dest.push_back(tag[dest_width-1:0]);
                blocks_done++;
                model_sum[ch] = 0;
                model_cnt[ch] = 0;
            end
        end
    endfunction

    task automatic send_sample(input int d, input int tag);
        @(posedge clock);
        in_valid <= 1'b1;
        in_data  <= d[data_width-1:0];
        in_dest  <= tag[dest_width-1:0];
        model_add(d, tag);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clock);
            in_valid <= 1'b0;
        end
    endtask

    task automatic set_ratio(input int r);
        @(posedge clock);
        in_valid         <= 1'b0;
        decimation_ratio <= r[ratio_width-1:0];
        model_set_ratio(r);
        // Flush passes before the next sample
        idle(2);
    endtask

    // Output monitor, values stable at the falling edge
    always @(negedge clock) begin
        if (rst_n && out_valid) begin
            got_data.push_back(out_data);
            got_dest.push_back(out_dest);
            got_time.push_back($time);
            outputs_seen++;
        end
    end

    // Wait for the expected pulses, then compare in order
    task automatic check_outputs();
        int waited;
        int n;
        waited = 0;
        while (got_data.size() < exp_data.size() && waited < pipe_depth + 4) begin
            @(posedge clock);
            waited++;
        end
        // Room for a stray pulse still in the pipeline
        repeat (pipe_depth + 1) @(posedge clock);
        if (got_data.size() != exp_data.size()) begin
            $display("Wrong number of outputs at time %0t: expected %0d, saw %0d",
                     $time, exp_data.size(), got_data.size());
            error_count++;
        end
        n = (got_data.size() < exp_data.size()) ? got_data.size() : exp_data.size();
        for (int i = 0; i < n; i++) begin
            check_count++;
            if (got_data[i] !== exp_data[i]) begin
                $display("** Error at time %0t: out_data expected %h, got %h",
                         got_time[i], exp_data[i], got_data[i]);
                error_count++;
            end
            if (got_dest[i] !== exp_dest[i]) begin
                $display("** Error at time %0t: out_dest expected %h, got %h",
                         got_time[i], exp_dest[i], got_dest[i]);
                error_count++;
            end
        end
        exp_data.delete();
        exp_dest.delete();
        got_data.delete();
        got_dest.delete();
        got_time.delete();
    endtask

    function automatic void report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
    endfunction

    // -10 -7 and -3 4 give -8 and 0
    task automatic test_rounding();
        int e0;
        e0 = error_count;
        set_ratio(2);
        send_sample(-10, 3);
        send_sample(-7, 3);
        send_sample(-3, 3);
        send_sample(4, 3);
        idle(1);
        check_outputs();
        report_test("ratio 2 truncation toward zero", e0);
    endtask

    task automatic test_extremes();
        int e0;
        e0 = error_count;
        set_ratio(2);
        repeat (4) send_sample(32767, 0);
        repeat (4) send_sample(-32768, 0);
        idle(1);
        check_outputs();
        report_test("full scale samples", e0);
    endtask

    // Two rounds over all channels, each channel keeps its own mean
    task automatic test_interleave();
        int e0;
        e0 = error_count;
        set_ratio(2);
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < n_channels; c++) begin
                send_sample((c - 2) * 1000 + r * 37 + c, c);
            end
        end
        idle(1);
        check_outputs();
        report_test("interleaved channels", e0);
    endtask

    // Partial block at ratio 2 is lost when the ratio becomes 3
    task automatic test_ratio_flush();
        int e0;
        e0 = error_count;
        set_ratio(2);
        send_sample(100, 1);
        set_ratio(3);
        repeat (3) send_sample(4, 1);
        repeat (3) send_sample(8, 1);
        idle(1);
        check_outputs();
        report_test("ratio change flush", e0);
    endtask

    // Every invalid tag sits inside an open block on channel 2
    task automatic test_bad_tags();
        int e0;
        e0 = error_count;
        set_ratio(3);
        send_sample(30, 2);
        for (int t = n_channels; t < 256; t++) begin
            send_sample(int'(take_bits(data_width)), t);
        end
        send_sample(60, 2);
        send_sample(90, 2);
        idle(1);
        check_outputs();
        report_test("invalid channel tags", e0);
    endtask

    // 8 segments of 25 samples, random ratio per segment, random gaps
    task automatic test_random();
        int e0;
        int o0;
        int b0;
        int r;
        int ch;
        e0 = error_count;
        o0 = outputs_seen;
        b0 = blocks_done;
        for (int seg = 0; seg < 8; seg++) begin
            r = 0;
            while (r == 0) begin
                r = int'(take_bits(ratio_width));
            end
            set_ratio(r);
            for (int k = 0; k < 25; k++) begin
                ch = int'(take_bits(chan_width));
                send_sample(int'(take_bits(data_width)), ch);
                if (take_bits(2) == 0) begin
                    idle(1);
                end
            end
        end
        idle(1);
        check_outputs();
        if (outputs_seen - o0 != blocks_done - b0) begin
            $display("Random test saw %0d outputs but %0d blocks were completed",
                     outputs_seen - o0, blocks_done - b0);
            error_count++;
        end
        report_test("random samples and ratios", e0);
    endtask

    // Run limit
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Run stopped after %0d cycles before the tests finished", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        lfsr_state   = 32'hccd8;
        model_sum    = '{default: 0};
        model_cnt    = '{default: 0};
        model_ratio  = 1;
        blocks_done  = 0;
        cycle_count  = 0;
        outputs_seen = 0;
        error_count  = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n            <= 1'b0;
        in_valid         <= 1'b0;
        in_data          <= '0;
        in_dest          <= '0;
        decimation_ratio <= ratio_width'(1);
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        // Stored ratio fills and flushes once after reset
        idle(3);
        test_rounding();
        test_extremes();
        test_interleave();
        test_ratio_flush();
        test_bad_tags();
        test_random();
        $display("tests %0d, failed %0d, outputs checked %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/decimator_pkg.sv
rtl/channel_decode.sv
rtl/channel_accumulator.sv
rtl/average_output.sv
rtl/standard_decimator.sv
testbench/clock_gen.sv
testbench/decimator_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the decimator testbench with Verilator and run it
# Exit status is zero only when the run reports a pass

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert \
    --top-module decimator_tb \
    -Mdir obj_dir \
    -f sim.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vdecimator_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
    exit 0
fi

echo "simulation did not report a pass"
exit 1
